// ==== Makefile ====
TOOL  = verilator
FLAGS = --timing --assert
TOP   = tb_mem_pipe
FLIST = mem_pipe.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== mem_pipe.f ====
+incdir+verilog
verilog/mem_op_pkg.sv
verilog/mem_bus_pkg.sv
verilog/dcache_if.sv
verilog/dtlb.sv
verilog/load_align.sv
verilog/dcache.sv
verilog/mem_pipe_ctrl.sv
verilog/mem_pipe.sv
verification/wb_mem_model.sv
verification/tb_mem_pipe.sv

// ==== verification/tb_mem_pipe.sv ====
// Testbench for the load/store unit.
// Fills the TLB, runs loads and stores against the Wishbone memory model
// and compares every response with a reference model of the shadow state.
`default_nettype none
`timescale 1ns/100ps

`include "mem_pipe_defines.svh"

module tb_mem_pipe;
  import mem_op_pkg::*;
  import mem_bus_pkg::*;

  localparam int TIMEOUT = 50;
  localparam logic [`MP_VPN_W-1:0] VPN_A    = 20'h10000;
  localparam logic [`MP_VPN_W-1:0] VPN_B    = 20'h10001;
  localparam logic [`MP_VPN_W-1:0] VPN_RO   = 20'h20002;
  localparam logic [`MP_VPN_W-1:0] VPN_WO   = 20'h20003;
  // Same TLB slot as VPN_A, other tag
  localparam logic [`MP_VPN_W-1:0] VPN_MISS = 20'h30000;

  logic                 clk;
  logic                 reset;
  logic                 sfence;
  logic                 req_v;
  mem_op_e              req_op;
  logic [31:0]          req_base;
  logic [31:0]          req_imm;
  logic [63:0]          req_data;
  logic                 ready;
  logic                 resp_v;
  logic [63:0]          resp_data;
  mem_exc_e             resp_exc;
  logic                 fill_v;
  logic [`MP_VPN_W-1:0] fill_vpn;
  tlb_entry_s           fill_entry;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [31:0]          wb_adr;
  logic [7:0]           wb_sel;
  logic [63:0]          wb_dat_w;
  logic [63:0]          wb_dat_r;
  logic                 wb_ack;

  logic [63:0]          shadow [2048];
  logic                 tlb_valid [`MP_TLB_ENTRIES];
  logic [`MP_VPN_W-1:0] tlb_vpn [`MP_TLB_ENTRIES];
  logic [`MP_PPN_W-1:0] tlb_ppn [`MP_TLB_ENTRIES];
  logic                 tlb_r [`MP_TLB_ENTRIES];
  logic                 tlb_w [`MP_TLB_ENTRIES];

  logic [63:0]          exp_data_q [$];
  mem_exc_e             exp_exc_q [$];
  string                name_q [$];
  integer               seed;
  int                   errors;
  int                   checks;

  mem_pipe u_dut (
    .clk_i(clk), .reset_i(reset), .sfence_i(sfence),
    .req_v_i(req_v), .req_op_i(req_op), .req_base_i(req_base),
    .req_imm_i(req_imm), .req_data_i(req_data), .ready_o(ready),
    .resp_v_o(resp_v), .resp_data_o(resp_data), .resp_exc_o(resp_exc),
    .fill_v_i(fill_v), .fill_vpn_i(fill_vpn), .fill_entry_i(fill_entry),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_sel_o(wb_sel), .wb_dat_o(wb_dat_w), .wb_ack_i(wb_ack), .wb_dat_i(wb_dat_r)
  );

  wb_mem_model u_mem (
    .clk_i(clk), .reset_i(reset), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
    .wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_sel_i(wb_sel), .wb_dat_i(wb_dat_w),
    .wb_ack_o(wb_ack), .wb_dat_o(wb_dat_r)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int bytes_of(input mem_op_e op);
    case (op)
      e_lb, e_lbu, e_sb: return 1;
      e_lh, e_lhu, e_sh: return 2;
      e_lw, e_lwu, e_sw: return 4;
      default:           return 8;
    endcase
  endfunction

  function automatic logic is_store_op(input mem_op_e op);
    return (op == e_sb) || (op == e_sh) || (op == e_sw) || (op == e_sd);
  endfunction

  function automatic logic [31:0] phys_addr(input logic [31:0] va);
    return {tlb_ppn[va[13:12]], va[11:0]};
  endfunction

  // Alignment first, then translation, then permission, then lane extraction
  function automatic void expected_result(input mem_op_e op, input logic [31:0] va,
                                          output logic [63:0] data, output mem_exc_e exc);
    int          n;
    logic [1:0]  i;
    logic [31:0] pa;
    logic [63:0] lane;
    n    = bytes_of(op);
    i    = va[13:12];
    data = '0;
    if ((va[2:0] & 3'(n - 1)) != 3'd0)
      exc = e_exc_misaligned;
    else if (!tlb_valid[i] || tlb_vpn[i] != va[31:12])
      exc = e_exc_tlb_miss;
    else if (is_store_op(op) && !tlb_w[i])
      exc = e_exc_store_page_fault;
    else if (!is_store_op(op) && !tlb_r[i])
      exc = e_exc_load_page_fault;
    else
      exc = e_exc_none;
    if (exc == e_exc_none && !is_store_op(op)) begin
      pa   = phys_addr(va);
      lane = shadow[pa[13:3]] >> {va[2:0], 3'b000};
      case (op)
        e_lb:    data = {{56{lane[7]}}, lane[7:0]};
        e_lbu:   data = {56'd0, lane[7:0]};
        e_lh:    data = {{48{lane[15]}}, lane[15:0]};
        e_lhu:   data = {48'd0, lane[15:0]};
        e_lw:    data = {{32{lane[31]}}, lane[31:0]};
        e_lwu:   data = {32'd0, lane[31:0]};
        default: data = lane;
      endcase
    end
  endfunction

  function automatic void apply_store(input mem_op_e op, input logic [31:0] va,
                                      input logic [63:0] wdata);
    logic [31:0] pa;
    pa = phys_addr(va);
    for (int k = 0; k < bytes_of(op); k++)
      shadow[pa[13:3]][8 * (int'(va[2:0]) + k) +: 8] = wdata[8*k +: 8];
  endfunction

  function automatic logic [31:0] rand_addr(input logic [`MP_VPN_W-1:0] vpn, input int n);
    logic [31:0] r;
    r = $random(seed);
    return {vpn, r[11:0] & ~12'(n - 1)};
  endfunction

  task automatic report_and_finish();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout: %s", what);
    errors++;
    report_and_finish();
  endtask

  // Waits until every expected response has been compared
  task automatic drain_responses();
    int cnt;
    cnt = 0;
    while (name_q.size() != 0 && cnt < TIMEOUT) begin
      @(posedge clk);
      cnt++;
    end
    if (name_q.size() != 0)
      timeout_fail("responses were still outstanding at the end");
  endtask

  task automatic fill_tlb(input logic [`MP_VPN_W-1:0] vpn, input logic [`MP_PPN_W-1:0] ppn,
                          input logic can_read, input logic can_write);
    @(posedge clk);
    fill_v     <= 1'b1;
    fill_vpn   <= vpn;
    fill_entry <= '{ppn: ppn, r: can_read, w: can_write};
    @(posedge clk);
    fill_v <= 1'b0;
    tlb_valid[vpn[1:0]] = 1'b1;
    tlb_vpn[vpn[1:0]]   = vpn;
    tlb_ppn[vpn[1:0]]   = ppn;
    tlb_r[vpn[1:0]]     = can_read;
    tlb_w[vpn[1:0]]     = can_write;
  endtask

  task automatic flush_tlb();
    @(posedge clk);
    sfence <= 1'b1;
    @(posedge clk);
    sfence <= 1'b0;
    for (int i = 0; i < `MP_TLB_ENTRIES; i++)
      tlb_valid[i] = 1'b0;
  endtask

  // One request, then wait for its response; reports any bus cycle seen
  task automatic access(input string name, input mem_op_e op, input logic [31:0] va,
                        input logic [63:0] wdata, output logic saw_cyc);
    logic [63:0] exp_data;
    mem_exc_e    exp_exc;
    logic [31:0] base;
    logic        ready_early;
    logic        stb_apart;
    int          cnt;
    base = $random(seed);
    expected_result(op, va, exp_data, exp_exc);
    if (exp_exc == e_exc_none && is_store_op(op))
      apply_store(op, va, wdata);
    name_q.push_back(name);
    exp_data_q.push_back(exp_data);
    exp_exc_q.push_back(exp_exc);
    saw_cyc     = 1'b0;
    ready_early = 1'b0;
    stb_apart   = 1'b0;
    @(posedge clk);
    req_v    <= 1'b1;
    req_op   <= op;
    req_base <= base;
    req_imm  <= va - base;
    req_data <= wdata;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (!ready && cnt < TIMEOUT);
    req_v <= 1'b0;
    if (!ready) begin
      timeout_fail({name, ": request was never accepted"});
    end else begin
      cnt = 0;
      do begin
        @(posedge clk);
        saw_cyc     = saw_cyc | wb_cyc;
        ready_early = ready_early | (ready & ~resp_v);
        stb_apart   = stb_apart | (wb_stb != wb_cyc);
        cnt++;
      end while (!resp_v && cnt < TIMEOUT);
      if (!resp_v) begin
        timeout_fail({name, ": no response arrived"});
      end else begin
        checks = checks + 3;
        assert (!ready_early) else begin
          errors++;
          $display("Error %s: ready went high before the response", name);
        end
        assert (ready) else begin
          errors++;
          $display("Error %s: ready was low in the response cycle", name);
        end
        assert (!stb_apart) else begin
          errors++;
          $display("Error %s: Wishbone strobe and cycle differed", name);
        end
      end
    end
  endtask

  task automatic check_no_bus(input string name, input logic saw_cyc);
    checks++;
    assert (!saw_cyc) else begin
      errors++;
      $display("Error %s: a Wishbone cycle ran where none was expected", name);
    end
  endtask

  task automatic check_mem(input string name, input logic [31:0] va);
    logic [31:0] pa;
    pa = phys_addr(va);
    checks++;
    assert (u_mem.mem[pa[13:3]] == shadow[pa[13:3]]) else begin
      errors++;
      $display("Error %s: memory expected %h actual %h",
               name, shadow[pa[13:3]], u_mem.mem[pa[13:3]]);
    end
  endtask

  always @(posedge clk) begin : compare_resp
    string       name;
    logic [63:0] exp_data;
    mem_exc_e    exp_exc;
    if (!reset && resp_v) begin
      checks++;
      assert (name_q.size() != 0) else begin
        errors++;
        $display("A response arrived with no request outstanding");
      end
      if (name_q.size() != 0) begin
        name     = name_q.pop_front();
        exp_data = exp_data_q.pop_front();
        exp_exc  = exp_exc_q.pop_front();
        checks   = checks + 2;
        assert (resp_exc == exp_exc) else begin
          errors++;
          $display("Error %s: status expected %s actual %s",
                   name, exp_exc.name(), resp_exc.name());
        end
        assert (resp_data == exp_data) else begin
          errors++;
          $display("Error %s: data expected %h actual %h", name, exp_data, resp_data);
        end
      end
    end
  end

  initial begin : stimulus
    logic        saw_cyc;
    logic [31:0] va;
    logic [31:0] r;
    logic [31:0] hi;
    logic [31:0] lo;
    mem_op_e     op;
    mem_op_e     loads [7];
    mem_op_e     stores [4];
    mem_op_e     mis_ops [4];
    logic [31:0] mis_off [4];
    loads   = '{e_lb, e_lbu, e_lh, e_lhu, e_lw, e_lwu, e_ld};
    stores  = '{e_sb, e_sh, e_sw, e_sd};
    mis_ops = '{e_lh, e_lwu, e_ld, e_sw};
    mis_off = '{32'd1, 32'd2, 32'd4, 32'd5};
    seed       = 38;
    errors     = 0;
    checks     = 0;
    reset      = 1'b1;
    sfence     = 1'b0;
    req_v      = 1'b0;
    req_op     = e_lb;
    req_base   = '0;
    req_imm    = '0;
    req_data   = '0;
    fill_v     = 1'b0;
    fill_vpn   = '0;
    fill_entry = '0;
    for (int i = 0; i < `MP_TLB_ENTRIES; i++)
      tlb_valid[i] = 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < 2048; i++)
      shadow[i] = u_mem.mem[i];

    fill_tlb(VPN_A, 20'd1, 1'b1, 1'b1);
    fill_tlb(VPN_B, 20'd2, 1'b1, 1'b1);
    fill_tlb(VPN_RO, 20'd3, 1'b1, 1'b0);
    fill_tlb(VPN_WO, 20'd0, 1'b0, 1'b1);

    // Loads of every size and sign
    for (int t = 0; t < 40; t++) begin
      r  = $random(seed);
      op = loads[int'(r[2:0]) % 7];
      va = rand_addr(r[4] ? VPN_B : (r[5] ? VPN_RO : VPN_A), bytes_of(op));
      access("random load", op, va, 64'd0, saw_cyc);
    end

    // Stores, half of them to a line already in the cache
    for (int t = 0; t < 8; t++) begin
      r  = $random(seed);
      hi = $random(seed);
      lo = $random(seed);
      op = stores[t % 4];
      va = rand_addr(r[0] ? VPN_B : VPN_A, bytes_of(op));
      if ((t % 2) == 0)
        access("warm line", e_ld, {va[31:3], 3'b000}, 64'd0, saw_cyc);
      access("store", op, va, {hi, lo}, saw_cyc);
      check_mem("write-through", va);
      access("dword load after store", e_ld, {va[31:3], 3'b000}, 64'd0, saw_cyc);
      access("byte load after store", e_lbu, va, 64'd0, saw_cyc);
    end

    for (int t = 0; t < 4; t++) begin
      va = rand_addr(VPN_A, 8);
      access("line fill", e_lw, va, 64'd0, saw_cyc);
      access("repeat load", e_lwu, va + 32'd4, 64'd0, saw_cyc);
      check_no_bus("repeat load hit", saw_cyc);
    end

    va = rand_addr(VPN_B, 8);
    for (int t = 0; t < 4; t++) begin
      access("misaligned", mis_ops[t], va + mis_off[t], 64'hdead_beef_0bad_f00d, saw_cyc);
      check_no_bus("misaligned", saw_cyc);
    end
    check_mem("misaligned store", va);

    va = rand_addr(VPN_RO, 4);
    access("store to read-only page", e_sw, va, 64'h1234_5678_9abc_def0, saw_cyc);
    check_no_bus("store to read-only page", saw_cyc);
    check_mem("store to read-only page", va);
    va = rand_addr(VPN_WO, 8);
    access("load from write-only page", e_lh, va, 64'd0, saw_cyc);
    check_no_bus("load from write-only page", saw_cyc);
    check_mem("load from write-only page", va);
    access("store to write-only page", e_sd, va, 64'h0f1e_2d3c_4b5a_6978, saw_cyc);
    check_mem("store to write-only page", va);

    va = rand_addr(VPN_MISS, 8);
    access("unfilled page", e_ld, va, 64'd0, saw_cyc);
    check_no_bus("unfilled page", saw_cyc);
    va = rand_addr(VPN_A, 8);
    access("before sfence", e_ld, va, 64'd0, saw_cyc);
    flush_tlb();
    access("after sfence", e_ld, va, 64'd0, saw_cyc);
    check_no_bus("after sfence", saw_cyc);

    drain_responses();
    report_and_finish();
  end

endmodule

`default_nettype wire

// ==== verification/wb_mem_model.sv ====
// Wishbone classic slave memory for the load/store unit testbench.
// Holds 16 KiB of dwords, indexed by physical address bits 13:3, and
// acks each transfer after a random wait of zero to three cycles.
`default_nettype none
`timescale 1ns/100ps

module wb_mem_model (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [31:0] wb_adr_i,
  input  logic [7:0]  wb_sel_i,
  input  logic [63:0] wb_dat_i,
  output logic        wb_ack_o,
  output logic [63:0] wb_dat_o
);

  localparam int WORDS = 2048;

  logic [63:0] mem [WORDS];
  logic [10:0] idx;
  logic        busy;
  logic [1:0]  wait_cnt;
  logic [31:0] rnd;
  integer      seed;

  // Initial contents mix the whole byte address into both halves
  function automatic logic [63:0] fill_word(input logic [31:0] addr);
    return {addr ^ 32'h5a3c_96e1, addr * 32'h9e37_79b1 + 32'h0123_4567};
  endfunction

  initial begin
    seed     = 38;
    wb_ack_o = 1'b0;
    wb_dat_o = '0;
    for (int i = 0; i < WORDS; i++)
      mem[i] = fill_word(32'(i * 8));
  end

  assign idx = wb_adr_i[13:3];

  always @(posedge clk_i) begin
    if (reset_i) begin
      wb_ack_o <= 1'b0;
      busy     <= 1'b0;
      wait_cnt <= 2'd0;
    end else begin
      wb_ack_o <= 1'b0;
      if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
        if (!busy) begin
          rnd = $random(seed);
          wait_cnt <= rnd[1:0];
          busy     <= 1'b1;
        end else if (wait_cnt != 2'd0) begin
          wait_cnt <= wait_cnt - 2'd1;
        end else begin
          busy     <= 1'b0;
          wb_ack_o <= 1'b1;
          wb_dat_o <= mem[idx];
          // Byte lanes are written as the ack goes out
          if (wb_we_i) begin
            for (int k = 0; k < 8; k++)
              if (wb_sel_i[k])
                mem[idx][8*k +: 8] = wb_dat_i[8*k +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dcache.sv ====
// Direct-mapped write-through data cache with one dword per line,
// plus the Wishbone classic master that serves refills and stores.
// Stores never allocate; a store hit updates the line in place.
`default_nettype none
`timescale 1ns/100ps

`include "mem_pipe_defines.svh"

module dcache (
  input  logic                   clk_i,
  input  logic                   reset_i,
  dcache_if.cache                cache,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic                   wb_we_o,
  output logic [`MP_PADDR_W-1:0] wb_adr_o,
  output logic [7:0]             wb_sel_o,
  output logic [63:0]            wb_dat_o,
  input  logic                   wb_ack_i,
  input  logic [63:0]            wb_dat_i
);
  import mem_bus_pkg::*;

  localparam int IDX_W = $clog2(`MP_DCACHE_LINES);
  localparam int TAG_W = `MP_PADDR_W - 3 - IDX_W;

  logic [`MP_DCACHE_LINES-1:0] valid_r;
  logic [TAG_W-1:0]            tag_r  [`MP_DCACHE_LINES];
  dword_u                      data_r [`MP_DCACHE_LINES];
  logic [IDX_W-1:0]            lookup_idx, bus_idx;
  logic [TAG_W-1:0]            lookup_tag, bus_tag;
  logic [63:0]                 byte_mask;
  dword_u                      merged;
  logic                        start;
  logic                        cyc_r;
  logic                        ack;

  assign lookup_idx = cache.paddr[3 +: IDX_W];
  assign lookup_tag = cache.paddr[`MP_PADDR_W-1 -: TAG_W];
  assign bus_idx    = wb_adr_o[3 +: IDX_W];
  assign bus_tag    = wb_adr_o[`MP_PADDR_W-1 -: TAG_W];

  assign cache.hit = cache.lookup_v & valid_r[lookup_idx]
                   & (tag_r[lookup_idx] == lookup_tag);

  // Refill data is forwarded straight from the bus on ack
  assign cache.rdata = cyc_r ? wb_dat_i : data_r[lookup_idx].raw;

  always_comb begin
    for (int i = 0; i < 8; i++)
      byte_mask[8*i +: 8] = {8{cache.wsel[i]}};
  end

  assign merged.raw = (data_r[lookup_idx].raw & ~byte_mask) | (cache.wdata & byte_mask);

  assign start      = cache.miss_refill | cache.store_write;
  assign ack        = cyc_r & wb_ack_i;
  assign cache.done = ack;

  always_ff @(posedge clk_i) begin
    if (reset_i)
      cyc_r <= 1'b0;
    else if (ack)
      cyc_r <= 1'b0;
    else if (start)
      cyc_r <= 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      wb_we_o  <= cache.store_write;
      wb_adr_o <= {cache.paddr[`MP_PADDR_W-1:3], 3'b000};
      wb_sel_o <= cache.store_write ? cache.wsel : 8'hff;
      wb_dat_o <= cache.wdata;
    end
  end

  assign wb_cyc_o = cyc_r;
  assign wb_stb_o = cyc_r;

  always_ff @(posedge clk_i) begin
    if (reset_i)
      valid_r <= '0;
    else if (ack && !wb_we_o)
      valid_r[bus_idx] <= 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (ack && !wb_we_o) begin
      tag_r[bus_idx]      <= bus_tag;
      data_r[bus_idx].raw <= wb_dat_i;
    end else if (cache.store_write && cache.hit) begin
      data_r[lookup_idx] <= merged;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dcache_if.sv ====
// Request and completion signals between the control FSM and the data cache.
// The control side asks for lookups and bus transfers, the cache answers.
`default_nettype none
`timescale 1ns/100ps

`include "mem_pipe_defines.svh"

interface dcache_if;

  logic                   lookup_v;
  logic [`MP_PADDR_W-1:0] paddr;
  logic                   hit;
  logic [63:0]            rdata;
  logic                   miss_refill;
  logic                   store_write;
  logic [7:0]             wsel;
  logic [63:0]            wdata;
  // One pulse per finished Wishbone transfer
  logic                   done;

  modport ctrl (
    output lookup_v, paddr, miss_refill, store_write, wsel, wdata,
    input  hit, rdata, done
  );

  modport cache (
    input  lookup_v, paddr, miss_refill, store_write, wsel, wdata,
    output hit, rdata, done
  );

endinterface

`default_nettype wire

// ==== verilog/dtlb.sv ====
// Direct-mapped data TLB, indexed by the low virtual page number bits.
// Entries come in through the fill port; sfence clears them all at once.
// Lookup is combinational.
`default_nettype none
`timescale 1ns/100ps

`include "mem_pipe_defines.svh"

module dtlb (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    flush_i,
  input  logic                    fill_v_i,
  input  logic [`MP_VPN_W-1:0]    fill_vpn_i,
  input  mem_bus_pkg::tlb_entry_s fill_entry_i,
  input  logic [`MP_VPN_W-1:0]    lookup_vpn_i,
  output logic                    hit_o,
  output mem_bus_pkg::tlb_entry_s entry_o
);
  import mem_bus_pkg::*;

  localparam int IDX_W = $clog2(`MP_TLB_ENTRIES);
  localparam int TAG_W = `MP_VPN_W - IDX_W;

  logic [`MP_TLB_ENTRIES-1:0] valid_r;
  logic [TAG_W-1:0]           tag_r   [`MP_TLB_ENTRIES];
  tlb_entry_s                 entry_r [`MP_TLB_ENTRIES];
  logic [IDX_W-1:0]           fill_idx, lookup_idx;
  logic [TAG_W-1:0]           fill_tag, lookup_tag;

  assign fill_idx   = fill_vpn_i[IDX_W-1:0];
  assign fill_tag   = fill_vpn_i[`MP_VPN_W-1:IDX_W];
  assign lookup_idx = lookup_vpn_i[IDX_W-1:0];
  assign lookup_tag = lookup_vpn_i[`MP_VPN_W-1:IDX_W];

  // Flush takes priority over a fill in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i)
      valid_r <= '0;
    else if (fill_v_i)
      valid_r[fill_idx] <= 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      tag_r[fill_idx]   <= fill_tag;
      entry_r[fill_idx] <= fill_entry_i;
    end
  end

  assign hit_o   = valid_r[lookup_idx] & (tag_r[lookup_idx] == lookup_tag);
  assign entry_o = entry_r[lookup_idx];

endmodule

`default_nettype wire

// ==== verilog/load_align.sv ====
// Lane logic for loads and stores within one dword.
// Loads pick the addressed lane and extend it; stores replicate the
// data into every lane and produce the byte selects.
`default_nettype none
`timescale 1ns/100ps

module load_align (
  input  mem_op_pkg::mem_op_e op_i,
  input  logic [2:0]          offset_i,
  input  logic [63:0]         line_i,
  input  logic [63:0]         store_data_i,
  output logic [63:0]         rdata_o,
  output logic [7:0]          wsel_o,
  output logic [63:0]         wdata_o
);
  import mem_op_pkg::*;
  import mem_bus_pkg::*;

  dword_u      line;
  dword_u      sdata;
  dword_u      lanes;
  logic [7:0]  lane_b;
  logic [15:0] lane_h;
  logic [31:0] lane_w;
  logic        sext;

  assign line.raw  = line_i;
  assign sdata.raw = store_data_i;

  assign lane_b = line.b[offset_i];
  assign lane_h = line.h[offset_i[2:1]];
  assign lane_w = line.w[offset_i[2]];
  assign sext   = ~mem_op_is_unsigned(op_i);

  always_comb begin
    case (mem_op_size(op_i))
      e_size_b: rdata_o = {{56{sext & lane_b[7]}}, lane_b};
      e_size_h: rdata_o = {{48{sext & lane_h[15]}}, lane_h};
      e_size_w: rdata_o = {{32{sext & lane_w[31]}}, lane_w};
      default:  rdata_o = line.raw;
    endcase
  end

  always_comb begin
    lanes.raw = sdata.raw;
    wsel_o    = 8'hff;
    case (mem_op_size(op_i))
      e_size_b: begin
        for (int i = 0; i < 8; i++)
          lanes.b[i] = sdata.b[0];
        wsel_o = 8'h01 << offset_i;
      end
      e_size_h: begin
        for (int i = 0; i < 4; i++)
          lanes.h[i] = sdata.h[0];
        wsel_o = 8'h03 << {offset_i[2:1], 1'b0};
      end
      e_size_w: begin
        for (int i = 0; i < 2; i++)
          lanes.w[i] = sdata.w[0];
        wsel_o = 8'h0f << {offset_i[2], 2'b00};
      end
      default: ;
    endcase
  end

  assign wdata_o = lanes.raw;

endmodule

`default_nettype wire

// ==== verilog/mem_bus_pkg.sv ====
// Data and storage formats used by the datapath blocks.
// A dword is viewed as raw bits or as byte, half and word lanes.
`default_nettype none

`include "mem_pipe_defines.svh"

package mem_bus_pkg;

  typedef union packed {
    logic [63:0]      raw;
    logic [7:0][7:0]  b;
    logic [3:0][15:0] h;
    logic [1:0][31:0] w;
  } dword_u;

  // Valid bit and tag are kept by the TLB itself
  typedef struct packed {
    logic [`MP_PPN_W-1:0] ppn;
    logic                 r;
    logic                 w;
  } tlb_entry_s;

endpackage

`default_nettype wire

// ==== verilog/mem_op_pkg.sv ====
// Operation, access size and result status of memory instructions.
// Shared by the control FSM, the lane logic and the testbench.
`default_nettype none

package mem_op_pkg;

  typedef enum logic [3:0] {
    e_lb, e_lbu, e_lh, e_lhu, e_lw, e_lwu, e_ld,
    e_sb, e_sh, e_sw, e_sd
  } mem_op_e;

  // Encoded as log2 of the byte count
  typedef enum logic [1:0] {
    e_size_b = 2'd0,
    e_size_h = 2'd1,
    e_size_w = 2'd2,
    e_size_d = 2'd3
  } mem_size_e;

  typedef enum logic [2:0] {
    e_exc_none,
    e_exc_misaligned,
    e_exc_tlb_miss,
    e_exc_load_page_fault,
    e_exc_store_page_fault
  } mem_exc_e;

  function automatic mem_size_e mem_op_size(mem_op_e op);
    case (op)
      e_lb, e_lbu, e_sb: return e_size_b;
      e_lh, e_lhu, e_sh: return e_size_h;
      e_lw, e_lwu, e_sw: return e_size_w;
      default:           return e_size_d;
    endcase
  endfunction

  function automatic logic mem_op_is_store(mem_op_e op);
    return op inside {e_sb, e_sh, e_sw, e_sd};
  endfunction

  function automatic logic mem_op_is_unsigned(mem_op_e op);
    return op inside {e_lbu, e_lhu, e_lwu};
  endfunction

endpackage

`default_nettype wire

// ==== verilog/mem_pipe.sv ====
// Top level of the load/store unit.
// Connects the control FSM, data TLB, data cache and lane logic, and
// exposes the request, response, TLB fill and Wishbone master ports.
`default_nettype none
`timescale 1ns/100ps

`include "mem_pipe_defines.svh"

module mem_pipe (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    sfence_i,
  input  logic                    req_v_i,
  input  mem_op_pkg::mem_op_e     req_op_i,
  input  logic [`MP_VADDR_W-1:0]  req_base_i,
  input  logic [`MP_VADDR_W-1:0]  req_imm_i,
  input  logic [63:0]             req_data_i,
  output logic                    ready_o,
  output logic                    resp_v_o,
  output logic [63:0]             resp_data_o,
  output mem_op_pkg::mem_exc_e    resp_exc_o,
  input  logic                    fill_v_i,
  input  logic [`MP_VPN_W-1:0]    fill_vpn_i,
  input  mem_bus_pkg::tlb_entry_s fill_entry_i,
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output logic                    wb_we_o,
  output logic [`MP_PADDR_W-1:0]  wb_adr_o,
  output logic [7:0]              wb_sel_o,
  output logic [63:0]             wb_dat_o,
  input  logic                    wb_ack_i,
  input  logic [63:0]             wb_dat_i
);
  import mem_op_pkg::*;
  import mem_bus_pkg::*;

  logic [`MP_VPN_W-1:0] tlb_vpn;
  logic                 tlb_hit;
  tlb_entry_s           tlb_entry;
  mem_op_e              align_op;
  logic [2:0]           align_offset;
  logic [63:0]          align_store_data;
  logic [7:0]           align_wsel;
  logic [63:0]          align_wdata;
  logic [63:0]          align_rdata;

  dcache_if cache_bus ();

  mem_pipe_ctrl u_ctrl (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_v_i        (req_v_i),
    .req_op_i       (req_op_i),
    .req_base_i     (req_base_i),
    .req_imm_i      (req_imm_i),
    .req_data_i     (req_data_i),
    .ready_o        (ready_o),
    .tlb_vpn_o      (tlb_vpn),
    .tlb_hit_i      (tlb_hit),
    .tlb_entry_i    (tlb_entry),
    .cache          (cache_bus.ctrl),
    .align_op_o     (align_op),
    .align_offset_o (align_offset),
    .align_wdata_o  (align_store_data),
    .align_wsel_i   (align_wsel),
    .align_wdata_i  (align_wdata),
    .align_rdata_i  (align_rdata),
    .resp_v_o       (resp_v_o),
    .resp_data_o    (resp_data_o),
    .resp_exc_o     (resp_exc_o)
  );

  dtlb u_dtlb (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flush_i      (sfence_i),
    .fill_v_i     (fill_v_i),
    .fill_vpn_i   (fill_vpn_i),
    .fill_entry_i (fill_entry_i),
    .lookup_vpn_i (tlb_vpn),
    .hit_o        (tlb_hit),
    .entry_o      (tlb_entry)
  );

  dcache u_dcache (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .cache    (cache_bus.cache),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_we_o  (wb_we_o),
    .wb_adr_o (wb_adr_o),
    .wb_sel_o (wb_sel_o),
    .wb_dat_o (wb_dat_o),
    .wb_ack_i (wb_ack_i),
    .wb_dat_i (wb_dat_i)
  );

  // Line data comes from the cache array or the bus during a refill
  load_align u_align (
    .op_i         (align_op),
    .offset_i     (align_offset),
    .line_i       (cache_bus.rdata),
    .store_data_i (align_store_data),
    .rdata_o      (align_rdata),
    .wsel_o       (align_wsel),
    .wdata_o      (align_wdata)
  );

endmodule

`default_nettype wire

// ==== verilog/mem_pipe_ctrl.sv ====
// Control FSM of the load/store unit.
// Registers one request, checks alignment and permissions, and then either
// answers at once or waits for a refill or write-through on the bus.
`default_nettype none
`timescale 1ns/100ps

`include "mem_pipe_defines.svh"

module mem_pipe_ctrl (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_v_i,
  input  mem_op_pkg::mem_op_e     req_op_i,
  input  logic [`MP_VADDR_W-1:0]  req_base_i,
  input  logic [`MP_VADDR_W-1:0]  req_imm_i,
  input  logic [63:0]             req_data_i,
  output logic                    ready_o,
  output logic [`MP_VPN_W-1:0]    tlb_vpn_o,
  input  logic                    tlb_hit_i,
  input  mem_bus_pkg::tlb_entry_s tlb_entry_i,
  dcache_if.ctrl                  cache,
  output mem_op_pkg::mem_op_e     align_op_o,
  output logic [2:0]              align_offset_o,
  output logic [63:0]             align_wdata_o,
  input  logic [7:0]              align_wsel_i,
  input  logic [63:0]             align_wdata_i,
  input  logic [63:0]             align_rdata_i,
  output logic                    resp_v_o,
  output logic [63:0]             resp_data_o,
  output mem_op_pkg::mem_exc_e    resp_exc_o
);
  import mem_op_pkg::*;

  typedef enum logic [1:0] {s_idle, s_lookup, s_bus, s_respond} state_e;

  state_e                 state_r, state_n;
  mem_op_e                op_r;
  logic [`MP_VADDR_W-1:0] vaddr_r;
  logic [63:0]            data_r;
  logic                   accept;
  logic                   is_store;
  logic                   misaligned;
  mem_exc_e               exc;
  logic                   no_exc;
  logic [63:0]            resp_data_r;
  mem_exc_e               resp_exc_r;

  assign ready_o  = (state_r == s_idle) | (state_r == s_respond);
  assign accept   = req_v_i & ready_o;
  assign is_store = mem_op_is_store(op_r);

  // Effective address is formed as the request is taken
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_r    <= req_op_i;
      vaddr_r <= req_base_i + req_imm_i;
      data_r  <= req_data_i;
    end
  end

  always_comb begin
    case (mem_op_size(op_r))
      e_size_b: misaligned = 1'b0;
      e_size_h: misaligned = vaddr_r[0];
      e_size_w: misaligned = |vaddr_r[1:0];
      default:  misaligned = |vaddr_r[2:0];
    endcase
  end

  // Misalignment wins over translation faults
  always_comb begin
    if (misaligned)
      exc = e_exc_misaligned;
    else if (!tlb_hit_i)
      exc = e_exc_tlb_miss;
    else if (is_store && !tlb_entry_i.w)
      exc = e_exc_store_page_fault;
    else if (!is_store && !tlb_entry_i.r)
      exc = e_exc_load_page_fault;
    else
      exc = e_exc_none;
  end

  assign no_exc = (exc == e_exc_none);

  assign tlb_vpn_o         = vaddr_r[`MP_VADDR_W-1 -: `MP_VPN_W];
  assign cache.lookup_v    = (state_r == s_lookup);
  assign cache.paddr       = {tlb_entry_i.ppn, vaddr_r[`MP_PAGE_OFFSET_W-1:0]};
  assign cache.miss_refill = cache.lookup_v & no_exc & ~is_store & ~cache.hit;
  assign cache.store_write = cache.lookup_v & no_exc & is_store;
  assign cache.wsel        = align_wsel_i;
  assign cache.wdata       = align_wdata_i;

  assign align_op_o     = op_r;
  assign align_offset_o = vaddr_r[2:0];
  assign align_wdata_o  = data_r;

  always_comb begin
    state_n = state_r;
    case (state_r)
      s_idle:
        if (accept)
          state_n = s_lookup;
      s_lookup:
        if (!no_exc || (!is_store && cache.hit))
          state_n = s_respond;
        else
          state_n = s_bus;
      s_bus:
        if (cache.done)
          state_n = s_respond;
      default:
        state_n = accept ? s_lookup : s_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i)
      state_r <= s_idle;
    else
      state_r <= state_n;
  end

  // TLB may change during a bus wait, so the bus path reports no fault
  always_ff @(posedge clk_i) begin
    if (state_r == s_lookup && !no_exc) begin
      resp_exc_r  <= exc;
      resp_data_r <= '0;
    end else if ((state_r == s_lookup && !is_store && cache.hit)
                 || (state_r == s_bus && cache.done)) begin
      resp_exc_r  <= e_exc_none;
      resp_data_r <= is_store ? 64'd0 : align_rdata_i;
    end
  end

  assign resp_v_o    = (state_r == s_respond);
  assign resp_data_o = resp_data_r;
  assign resp_exc_o  = resp_exc_r;

endmodule

`default_nettype wire

// ==== verilog/mem_pipe_defines.svh ====
// Size parameters for the load/store unit.
// Included by every file that needs address, TLB or cache dimensions.

`ifndef MEM_PIPE_DEFINES_SVH
`define MEM_PIPE_DEFINES_SVH

`define MP_VADDR_W        32
`define MP_PADDR_W        32

// 4 KiB pages
`define MP_PAGE_OFFSET_W  12
`define MP_VPN_W          (`MP_VADDR_W - `MP_PAGE_OFFSET_W)
`define MP_PPN_W          (`MP_PADDR_W - `MP_PAGE_OFFSET_W)

`define MP_TLB_ENTRIES    4

// One dword per line, indexed by paddr[6:3]
`define MP_DCACHE_LINES   16

`endif
